//--- llc_pkg.sv
package llc_pkg;

    localparam int LINE_ADDR_BITS = 16;
    localparam int LINE_BITS      = 128;

    // the full line address doubles as the tag.
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0]      line_t;

    typedef enum logic [1:0] {
        REQ_READ  = 2'd0,
        REQ_WRITE = 2'd1,
        REQ_FLUSH = 2'd2
    } req_op_e;

endpackage

//--- llc_buf_if.sv
`timescale 1ns/10ps

interface llc_buf_if #(
    parameter int SET_BITS = 2,
    parameter int WAYS     = 4
);
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [WAY_BITS-1:0] way_t;

    logic                rd_en;
    set_t                rd_set;
    logic                wr_en;
    way_t                wr_way;
    logic                wr_valid;
    logic                wr_dirty;
    llc_pkg::line_addr_t wr_addr;
    llc_pkg::line_t      wr_line;
    logic                wr_line_en;  // keep the stored line when low.
    logic                evict_adv;

    llc_pkg::line_addr_t addrs [WAYS];
    logic [WAYS-1:0]     valids;
    logic [WAYS-1:0]     dirties;
    llc_pkg::line_t      lines [WAYS];
    way_t                evict_ptr;

    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                victim_valid;

    modport store (
        input  rd_en, rd_set, wr_en, wr_way, wr_valid, wr_dirty,
        input  wr_addr, wr_line, wr_line_en, evict_adv,
        output addrs, valids, dirties, lines, evict_ptr
    );

    modport proc (
        output rd_en, rd_set, wr_en, wr_way, wr_valid, wr_dirty,
        output wr_addr, wr_line, wr_line_en, evict_adv,
        input  addrs, valids, dirties, lines,
        input  hit, hit_way, victim_way, victim_valid
    );

    modport lookup (
        input  addrs, valids, evict_ptr,
        output hit, hit_way, victim_way, victim_valid
    );

endinterface

//--- llc_set_buf.sv
`timescale 1ns/10ps

module llc_set_buf #(
    parameter int SET_BITS = 2,
    parameter int WAYS     = 4
) (
    input  logic      clk,
    input  logic      rst,
    llc_buf_if.store  buf_if
);
    localparam int SETS     = 1 << SET_BITS;
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [WAY_BITS-1:0] way_t;

    llc_pkg::line_addr_t addr_mem [SETS][WAYS];
    llc_pkg::line_t      line_mem [SETS][WAYS];
    logic [WAYS-1:0]     valid_mem [SETS];
    logic [WAYS-1:0]     dirty_mem [SETS];
    way_t                ptr_mem [SETS];
    set_t                cur_set;  // set held in the buffer.
    way_t                ptr_next;

    assign ptr_next = (buf_if.evict_ptr == way_t'(WAYS - 1)) ? '0 : buf_if.evict_ptr + 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                ptr_mem[s]   <= '0;
            end
            cur_set          <= '0;
            buf_if.valids    <= '0;
            buf_if.dirties   <= '0;
            buf_if.evict_ptr <= '0;
        end else if (buf_if.rd_en) begin
            cur_set          <= buf_if.rd_set;
            buf_if.valids    <= valid_mem[buf_if.rd_set];
            buf_if.dirties   <= dirty_mem[buf_if.rd_set];
            buf_if.evict_ptr <= ptr_mem[buf_if.rd_set];
        end else begin
            if (buf_if.wr_en) begin
                valid_mem[cur_set][buf_if.wr_way] <= buf_if.wr_valid;
                dirty_mem[cur_set][buf_if.wr_way] <= buf_if.wr_dirty;
                buf_if.valids[buf_if.wr_way]      <= buf_if.wr_valid;
                buf_if.dirties[buf_if.wr_way]     <= buf_if.wr_dirty;
            end
            if (buf_if.evict_adv) begin
                ptr_mem[cur_set] <= ptr_next;
                buf_if.evict_ptr <= ptr_next;
            end
        end
    end

    // addresses and lines mean nothing until the valid bit is set.
    always_ff @(posedge clk) begin
        if (buf_if.rd_en) begin
            buf_if.addrs <= addr_mem[buf_if.rd_set];
            buf_if.lines <= line_mem[buf_if.rd_set];
        end else if (buf_if.wr_en) begin
            addr_mem[cur_set][buf_if.wr_way] <= buf_if.wr_addr;
            buf_if.addrs[buf_if.wr_way]      <= buf_if.wr_addr;
            if (buf_if.wr_line_en) begin
                line_mem[cur_set][buf_if.wr_way] <= buf_if.wr_line;
                buf_if.lines[buf_if.wr_way]      <= buf_if.wr_line;
            end
        end
    end

endmodule

//--- lookup_way.sv
`timescale 1ns/10ps

module lookup_way #(
    parameter int SET_BITS = 2,
    parameter int WAYS     = 4
) (
    input  llc_pkg::line_addr_t addr,
    llc_buf_if.lookup           buf_if
);
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int ADDR_MSB = llc_pkg::LINE_ADDR_BITS - 1;

    typedef logic [WAY_BITS-1:0] way_t;

    // low bits equal the buffered set index, so only the upper bits are compared.
    always_comb begin
        buf_if.hit     = 1'b0;
        buf_if.hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!buf_if.hit && buf_if.valids[w] &&
                buf_if.addrs[w][ADDR_MSB:SET_BITS] == addr[ADDR_MSB:SET_BITS]) begin
                buf_if.hit     = 1'b1;
                buf_if.hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        buf_if.victim_way   = buf_if.evict_ptr;  // round robin when the set is full.
        buf_if.victim_valid = 1'b1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!buf_if.valids[w]) begin
                buf_if.victim_way   = way_t'(w);
                buf_if.victim_valid = 1'b0;
            end
        end
    end

endmodule

//--- process_request.sv
`timescale 1ns/10ps

module process_request #(
    parameter int SET_BITS = 2,
    parameter int WAYS     = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  llc_pkg::req_op_e    req_op,
    input  llc_pkg::line_addr_t req_addr,
    input  llc_pkg::line_t      req_line,
    input  logic                mem_req_ready,
    input  logic                mem_rsp_valid,
    input  llc_pkg::line_t      mem_rsp_line,
    output logic                busy,
    output logic                done,
    output llc_pkg::line_t      rsp_line,
    output logic                mem_req_valid,
    output logic                mem_req_write,
    output llc_pkg::line_addr_t mem_req_addr,
    output llc_pkg::line_t      mem_req_line,
    llc_buf_if                  buf_if
);
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [WAY_BITS-1:0] way_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEBACK, FILL_REQ,
        FILL_WAIT, INSTALL, FLUSH_READ, FLUSH_WAY
    } state_e;

    state_e              state;
    llc_pkg::req_op_e    op_q;
    llc_pkg::line_addr_t addr_q;
    llc_pkg::line_t      line_q;
    way_t                way_q;
    logic                victim_valid_q;
    set_t                flush_set;
    way_t                flush_way;

    logic accept;
    logic mem_xfer;
    logic wb_needed;
    logic flush_dirty;
    logic flush_step;
    logic issue_wb;
    logic issue_fill;
    logic issue_flush_wb;

    lookup_way #(
        .SET_BITS (SET_BITS),
        .WAYS     (WAYS)
    ) lookup_i (
        .addr   (addr_q),
        .buf_if (buf_if)
    );

    assign accept      = (state == IDLE) && req_valid && !busy;
    assign mem_xfer    = mem_req_valid && mem_req_ready;
    assign wb_needed   = !buf_if.hit && buf_if.victim_valid && buf_if.dirties[buf_if.victim_way];
    assign flush_dirty = buf_if.valids[flush_way] && buf_if.dirties[flush_way];
    assign issue_wb    = (state == LOOKUP) && wb_needed;
    assign issue_fill  = (op_q == llc_pkg::REQ_READ) &&
                         (((state == LOOKUP) && !buf_if.hit && !wb_needed) ||
                          ((state == WRITEBACK) && mem_xfer));
    assign issue_flush_wb = (state == FLUSH_WAY) && !mem_req_valid && flush_dirty;
    assign flush_step  = (state == FLUSH_WAY) && (mem_req_valid ? mem_req_ready : !flush_dirty);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= IDLE;
            busy           <= 1'b0;
            done           <= 1'b0;
            mem_req_valid  <= 1'b0;
            victim_valid_q <= 1'b0;
            flush_set      <= '0;
            flush_way      <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            // a fill may follow a writeback on the very next edge.
            if (issue_wb || issue_fill || issue_flush_wb) begin
                mem_req_valid <= 1'b1;
            end else if (mem_xfer) begin
                mem_req_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (accept) begin
                        flush_set <= '0;
                        if (req_op == llc_pkg::REQ_FLUSH) begin
                            state <= FLUSH_READ;
                        end else begin
                            state <= LOOKUP;
                        end
                    end
                end
                LOOKUP: begin
                    victim_valid_q <= buf_if.victim_valid;
                    if (buf_if.hit) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else if (wb_needed) begin
                        state <= WRITEBACK;
                    end else if (issue_fill) begin
                        state <= FILL_REQ;
                    end else begin
                        state <= INSTALL;
                    end
                end
                WRITEBACK: begin
                    if (mem_xfer) begin
                        state <= issue_fill ? FILL_REQ : INSTALL;
                    end
                end
                FILL_REQ: begin
                    if (mem_xfer) begin
                        state <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (mem_rsp_valid) begin
                        state <= INSTALL;
                    end
                end
                INSTALL: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                FLUSH_READ: begin
                    flush_way <= '0;
                    state     <= FLUSH_WAY;
                end
                FLUSH_WAY: begin
                    if (flush_step && flush_way != way_t'(WAYS - 1)) begin
                        flush_way <= flush_way + 1'b1;
                    end else if (flush_step && flush_set == '1) begin
                        done  <= 1'b1;  // last way of last set.
                        state <= IDLE;
                    end else if (flush_step) begin
                        flush_set <= flush_set + 1'b1;
                        state     <= FLUSH_READ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= req_op;
            addr_q <= req_addr;
            line_q <= req_line;
        end else if (state == FILL_WAIT && mem_rsp_valid) begin
            line_q <= mem_rsp_line;
        end
        if (state == LOOKUP) begin
            way_q <= buf_if.victim_way;
        end
        if (state == LOOKUP && buf_if.hit && op_q == llc_pkg::REQ_READ) begin
            rsp_line <= buf_if.lines[buf_if.hit_way];
        end else if (state == INSTALL) begin
            rsp_line <= line_q;
        end
        if (issue_wb) begin
            mem_req_write <= 1'b1;
            mem_req_addr  <= buf_if.addrs[buf_if.victim_way];
            mem_req_line  <= buf_if.lines[buf_if.victim_way];
        end else if (issue_fill) begin
            mem_req_write <= 1'b0;
            mem_req_addr  <= addr_q;
            mem_req_line  <= '0;
        end else if (issue_flush_wb) begin
            mem_req_write <= 1'b1;
            mem_req_addr  <= buf_if.addrs[flush_way];
            mem_req_line  <= buf_if.lines[flush_way];
        end
    end

    always_comb begin
        buf_if.rd_en      = 1'b0;
        buf_if.rd_set     = flush_set;
        buf_if.wr_en      = 1'b0;
        buf_if.wr_way     = way_q;
        buf_if.wr_valid   = 1'b1;
        buf_if.wr_dirty   = 1'b1;
        buf_if.wr_addr    = addr_q;
        buf_if.wr_line    = line_q;
        buf_if.wr_line_en = 1'b1;
        buf_if.evict_adv  = 1'b0;
        case (state)
            IDLE: begin
                if (accept && req_op != llc_pkg::REQ_FLUSH) begin
                    buf_if.rd_en  = 1'b1;
                    buf_if.rd_set = req_addr[SET_BITS-1:0];
                end
            end
            FLUSH_READ: buf_if.rd_en = 1'b1;
            LOOKUP: begin
                if (buf_if.hit && op_q == llc_pkg::REQ_WRITE) begin
                    buf_if.wr_en  = 1'b1;  // overwrite in place.
                    buf_if.wr_way = buf_if.hit_way;
                end
            end
            INSTALL: begin
                buf_if.wr_en     = 1'b1;
                buf_if.wr_dirty  = (op_q == llc_pkg::REQ_WRITE);
                buf_if.evict_adv = victim_valid_q;
            end
            FLUSH_WAY: begin
                if (mem_xfer) begin
                    buf_if.wr_en      = 1'b1;  // line stays, dirty bit drops.
                    buf_if.wr_way     = flush_way;
                    buf_if.wr_dirty   = 1'b0;
                    buf_if.wr_addr    = buf_if.addrs[flush_way];
                    buf_if.wr_line_en = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- llc_core.sv
`timescale 1ns/10ps

module llc_core #(
    parameter int SET_BITS = 2,
    parameter int WAYS     = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  llc_pkg::req_op_e    req_op,
    input  llc_pkg::line_addr_t req_addr,
    input  llc_pkg::line_t      req_line,
    output logic                busy,
    output logic                done,
    output llc_pkg::line_t      rsp_line,
    output logic                mem_req_valid,
    output logic                mem_req_write,
    output llc_pkg::line_addr_t mem_req_addr,
    output llc_pkg::line_t      mem_req_line,
    input  logic                mem_req_ready,
    input  logic                mem_rsp_valid,
    input  llc_pkg::line_t      mem_rsp_line
);

    llc_buf_if #(
        .SET_BITS (SET_BITS),
        .WAYS     (WAYS)
    ) buf_if_i ();

    llc_set_buf #(
        .SET_BITS (SET_BITS),
        .WAYS     (WAYS)
    ) set_buf_i (
        .clk    (clk),
        .rst    (rst),
        .buf_if (buf_if_i)
    );

    process_request #(
        .SET_BITS (SET_BITS),
        .WAYS     (WAYS)
    ) proc_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_line      (req_line),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line),
        .busy          (busy),
        .done          (done),
        .rsp_line      (rsp_line),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_line  (mem_req_line),
        .buf_if        (buf_if_i)
    );

endmodule

//--- llc_core_tb.sv
`timescale 1ns/10ps

module llc_core_tb;
    localparam int SET_BITS = 2;
    localparam int WAYS     = 4;
    localparam int SETS     = 1 << SET_BITS;
    localparam int TIMEOUT_CYCLES = 4000;  // ~40 requests of under 60 cycles, with margin.

    logic                clk;
    logic                rst;
    logic                req_valid;
    llc_pkg::req_op_e    req_op;
    llc_pkg::line_addr_t req_addr;
    llc_pkg::line_t      req_line;
    logic                busy;
    logic                done;
    llc_pkg::line_t      rsp_line;
    logic                mem_req_valid;
    logic                mem_req_write;
    llc_pkg::line_addr_t mem_req_addr;
    llc_pkg::line_t      mem_req_line;
    logic                mem_req_ready;
    logic                mem_rsp_valid;
    llc_pkg::line_t      mem_rsp_line;

    llc_pkg::line_addr_t ref_addr [SETS][WAYS];
    llc_pkg::line_t      ref_line [SETS][WAYS];
    bit                  ref_valid [SETS][WAYS];
    bit                  ref_dirty [SETS][WAYS];
    int                  ref_ptr [SETS];

    // memory transfers still to come, oldest first.
    bit                  exp_write [$];
    llc_pkg::line_addr_t exp_addr [$];
    llc_pkg::line_t      exp_line [$];

    int errors, test_errors, tests_run, tests_failed, cycles, stall;
    bit                  rsp_pending;
    llc_pkg::line_addr_t rsp_addr;

    llc_core dut_i (
        .clk (clk), .rst (rst),
        .req_valid (req_valid), .req_op (req_op), .req_addr (req_addr), .req_line (req_line),
        .busy (busy), .done (done), .rsp_line (rsp_line),
        .mem_req_valid (mem_req_valid), .mem_req_write (mem_req_write),
        .mem_req_addr (mem_req_addr), .mem_req_line (mem_req_line),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid), .mem_rsp_line (mem_rsp_line)
    );

    always #50 clk = ~clk;

    function automatic llc_pkg::line_t mem_pattern(input llc_pkg::line_addr_t a);
        return {4{a, ~a}};
    endfunction

    function automatic llc_pkg::line_t random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act) else begin
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    // memory model, ready after 0 to 3 stall cycles.
    always @(negedge clk) begin
        mem_req_ready <= 1'b0;
        mem_rsp_valid <= 1'b0;
        if (rsp_pending) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_line  <= mem_pattern(rsp_addr);
            rsp_pending = 1'b0;
        end
        if (rst && mem_req_valid) begin
            if (stall == 0) begin
                mem_req_ready <= 1'b1;  // transfer on the next rising edge.
                stall = $urandom_range(3, 0);
                if (exp_write.size() == 0) begin
                    check_true(1'b0, "memory request when none was expected");
                end else begin
                    check_eq("mem_req_write", 128'(exp_write[0]), 128'(mem_req_write));
                    check_eq("mem_req_addr", 128'(exp_addr[0]), 128'(mem_req_addr));
                    if (exp_write[0]) begin
                        check_eq("mem_req_line", exp_line[0], mem_req_line);
                    end
                    void'(exp_write.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_line.pop_front());
                end
                if (!mem_req_write) begin
                    rsp_pending = 1'b1;
                    rsp_addr    = mem_req_addr;
                end
            end else begin
                stall--;
            end
        end
    end

    // a stalled request keeps valid and every field until its transfer.
    assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
            $stable(mem_req_addr) && $stable(mem_req_line))
    else begin
        $display("error: memory request changed or dropped while stalled");
        errors++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int find_way(input llc_pkg::line_addr_t a);
        int s;
        s = int'(a[SET_BITS-1:0]);
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[s][w] && ref_addr[s][w] == a) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic expect_mem(input bit wr, input llc_pkg::line_addr_t a, input llc_pkg::line_t l);
        exp_write.push_back(wr);
        exp_addr.push_back(a);
        exp_line.push_back(l);
    endtask

    task automatic model_miss(input llc_pkg::line_addr_t a, input bit wr, input llc_pkg::line_t l);
        int s;
        int v;
        s = int'(a[SET_BITS-1:0]);
        v = ref_ptr[s];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!ref_valid[s][w]) begin
                v = w;  // lowest invalid way wins.
            end
        end
        if (ref_valid[s][v] && ref_dirty[s][v]) begin
            expect_mem(1'b1, ref_addr[s][v], ref_line[s][v]);
        end
        if (!wr) begin
            expect_mem(1'b0, a, '0);
        end
        if (ref_valid[s][v]) begin
            ref_ptr[s] = (ref_ptr[s] + 1) % WAYS;
        end
        ref_valid[s][v] = 1'b1;
        ref_dirty[s][v] = wr;
        ref_addr[s][v]  = a;
        ref_line[s][v]  = wr ? l : mem_pattern(a);
    endtask

    task automatic model_flush();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                if (ref_valid[s][w] && ref_dirty[s][w]) begin
                    expect_mem(1'b1, ref_addr[s][w], ref_line[s][w]);
                    ref_dirty[s][w] = 1'b0;
                end
            end
        end
    endtask

    // called on a falling edge; returns on the falling edge after busy drops.
    task automatic do_request(input llc_pkg::req_op_e op, input llc_pkg::line_addr_t a,
                              input llc_pkg::line_t l);
        int  s;
        int  w;
        int  lat;
        bit  hit;
        s   = int'(a[SET_BITS-1:0]);
        w   = find_way(a);
        hit = (op != llc_pkg::REQ_FLUSH) && (w >= 0);
        if (op == llc_pkg::REQ_FLUSH) begin
            model_flush();
        end else if (hit && op == llc_pkg::REQ_WRITE) begin
            ref_line[s][w]  = l;
            ref_dirty[s][w] = 1'b1;
        end else if (!hit) begin
            model_miss(a, op == llc_pkg::REQ_WRITE, l);
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = a;
        req_line  = l;
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!done) begin
            check_true(busy, "busy low while a request is in progress");
            @(negedge clk);
            lat++;
        end
        check_true(busy, "busy low in the done cycle");
        if (hit) begin
            check_eq("done latency", 128'(2), 128'(lat));
        end
        if (op == llc_pkg::REQ_READ) begin
            check_eq("rsp_line", ref_line[s][find_way(a)], rsp_line);
        end
        @(negedge clk);
        check_true(!busy, "busy still high after done");
        check_true(exp_write.size() == 0, "an expected memory transfer never happened");
        exp_write.delete();
        exp_addr.delete();
        exp_line.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req_op        = llc_pkg::REQ_READ;
        req_addr      = '0;
        req_line      = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        void'($urandom(32'h5d9c));
        for (int s = 0; s < SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (4) @(negedge clk);
        rst = 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_eq("busy", 128'(1'b0), 128'(busy));
            check_eq("done", 128'(1'b0), 128'(done));
            check_eq("mem_req_valid", 128'(1'b0), 128'(mem_req_valid));
        end
        finish_test("reset");

        do_request(llc_pkg::REQ_READ, 16'h1230, '0);
        do_request(llc_pkg::REQ_READ, 16'h1230, '0);
        finish_test("read miss then hit");

        do_request(llc_pkg::REQ_WRITE, 16'h4561, random_line());
        do_request(llc_pkg::REQ_READ, 16'h4561, '0);
        do_request(llc_pkg::REQ_WRITE, 16'h4561, random_line());
        do_request(llc_pkg::REQ_READ, 16'h4561, '0);
        finish_test("write then read");

        for (int i = 1; i <= WAYS + 2; i++) begin
            do_request(llc_pkg::REQ_WRITE, 16'h0002 | 16'(i << 8), random_line());
        end
        do_request(llc_pkg::REQ_READ, 16'h0102, '0);
        finish_test("eviction");

        for (int i = 0; i < WAYS; i++) begin
            do_request(llc_pkg::REQ_WRITE, 16'h0a03 | 16'(i << 12), random_line());
        end
        stall = 3;  // long stall on the first writeback.
        do_request(llc_pkg::REQ_READ, 16'h7f03, '0);
        do_request(llc_pkg::REQ_READ, 16'h8003, '0);
        finish_test("back-pressure");

        do_request(llc_pkg::REQ_FLUSH, '0, '0);
        do_request(llc_pkg::REQ_FLUSH, '0, '0);
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                if (ref_valid[s][w]) begin
                    do_request(llc_pkg::REQ_READ, ref_addr[s][w], '0);
                end
            end
        end
        finish_test("flush");

        $display("tests: %0d run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- llc_core.f
llc_pkg.sv
llc_buf_if.sv
llc_set_buf.sv
lookup_way.sv
process_request.sv
llc_core.sv
llc_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= llc_core_tb
FLIST     ?= llc_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "sim passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
